// File: bench/clock_gen.sv
`default_nettype none

module clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;  // released on an edge
    end

    always #5 clk = ~clk;

endmodule

`default_nettype wire

// File: bench/sift_core_tb.sv
`default_nettype none

module sift_core_tb;

    import sift_pkg::*;

    localparam int n_tests = 7;
    localparam int npix = img_dim * img_dim;
    localparam int run_timeout = 5000;  // cycles from last load beat to done
    localparam int reset_timeout = 100;

    localparam int pat_flat = 0;
    localparam int pat_dot = 1;
    localparam int pat_checker = 2;
    localparam int pat_random = 3;
    localparam int pat_zero = 4;
    localparam int pat_corner_dot = 5;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic [15:0] in_data;
    logic        out_valid;
    kp_t         out_data;
    logic        done;

    string  test_name [n_tests];
    int     test_pat [n_tests];
    bit     test_gap [n_tests];

    pixel_t img [npix];
    kp_t    exp_kp [$];
    kp_t    got_kp [$];
    int     error_count;

    clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    sift_core dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .done      (done)
    );

    task automatic stop_on_error(input string what);
        error_count++;
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_kp(input string name, input int idx, input kp_t exp, input kp_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch %s keypoint %0d: expected %h, actual %h",
                                    name, idx, exp, act));
        end
    endtask

    task automatic check_count(input string name, input logic [kp_addr_w-1:0] exp,
                               input logic [kp_addr_w-1:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch %s keypoint count: expected %0d, actual %0d",
                                    name, exp, act));
        end
    endtask

    function automatic int pix_at(input int r, input int c);
        if (r < 0 || r >= img_dim || c < 0 || c >= img_dim) begin
            return 0;  // zero padding
        end
        return int'(img[r * img_dim + c]);
    endfunction

    // 1 at corners, 2 on edges, 4 in the centre
    function automatic int kernel_weight(input int dr, input int dc);
        return (2 - ((dr < 0) ? -dr : dr)) * (2 - ((dc < 0) ? -dc : dc));
    endfunction

    task automatic build_image(input int pat);
        int r;
        int c;
        for (int i = 0; i < npix; i++) begin
            r = i / img_dim;
            c = i % img_dim;
            case (pat)
                pat_flat:       img[i] = 8'd100;
                pat_dot:        img[i] = (r == 5 && c == 9) ? 8'd255 : 8'd0;
                pat_checker:    img[i] = ((r + c) % 2 == 1) ? 8'd200 : 8'd0;
                pat_random:     img[i] = pixel_t'($urandom);
                pat_corner_dot: img[i] = (r == 15 && c == 0) ? 8'd255 : 8'd0;
                default:        img[i] = 8'd0;
            endcase
        end
    endtask

    // expected keypoint list in raster order
    task automatic build_expected();
        int sum;
        int blur;
        int diff;
        exp_kp.delete();
        for (int r = 0; r < img_dim; r++) begin
            for (int c = 0; c < img_dim; c++) begin
                sum = 0;
                for (int dr = -1; dr <= 1; dr++) begin
                    for (int dc = -1; dc <= 1; dc++) begin
                        sum += kernel_weight(dr, dc) * pix_at(r + dr, c + dc);
                    end
                end
                blur = sum / 16;  // sum is never negative
                diff = pix_at(r, c) - blur;
                if (diff < 0) begin
                    diff = -diff;
                end
                if (diff > dog_thresh_def) begin
                    exp_kp.push_back({coord_w'(r), coord_w'(c), pix_w'(diff)});
                end
            end
        end
    endtask

    task automatic load_image(input bit gap);
        int idle;
        for (int i = 0; i < npix; i++) begin
            idle = gap ? int'($urandom_range(3, 0)) : 0;
            repeat (idle) begin
                @(posedge clk);
                in_valid <= 1'b0;
                in_data <= '0;
            end
            @(posedge clk);
            in_valid <= 1'b1;
            in_data <= {8'($urandom), img[i]};  // upper byte is junk
        end
        @(posedge clk);
        in_valid <= 1'b0;
        in_data <= '0;
    endtask

    task automatic collect_results(input string name);
        int waited;
        bit seen_done;
        got_kp.delete();
        waited = 0;
        seen_done = 1'b0;
        while (!seen_done) begin
            @(negedge clk);
            if (out_valid) begin
                got_kp.push_back(out_data);
            end
            if (done) begin
                if (out_valid) begin
                    stop_on_error($sformatf("In %s done came together with a keypoint beat",
                                            name));
                end
                seen_done = 1'b1;
            end
            waited++;
            if (!seen_done && waited > run_timeout) begin
                stop_on_error($sformatf("Timeout in %s: done never arrived", name));
            end
        end
    endtask

    task automatic wait_reset();
        int waited;
        waited = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            waited++;
            if (waited > reset_timeout) begin
                stop_on_error("Timeout: reset was never released");
            end
        end
    endtask

    task automatic run_test(input int idx);
        build_image(test_pat[idx]);
        build_expected();
        load_image(test_gap[idx]);
        collect_results(test_name[idx]);
        check_count(test_name[idx], kp_addr_w'(exp_kp.size()), kp_addr_w'(got_kp.size()));
        for (int k = 0; k < exp_kp.size(); k++) begin
            check_kp(test_name[idx], k, exp_kp[k], got_kp[k]);
        end
    endtask

    initial begin
        int seed_first;
        error_count = 0;
        seed_first = $urandom(32'h4a62_3332);
        in_valid = 1'b0;
        in_data = '0;

        test_name = '{"flat_100", "single_bright", "checkerboard", "random_gapped",
                      "all_zero", "back_to_back_first", "back_to_back_second"};
        test_pat = '{pat_flat, pat_dot, pat_checker, pat_random,
                     pat_zero, pat_random, pat_corner_dot};
        test_gap = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};

        wait_reset();
        // each load starts right after the previous done
        for (int i = 0; i < n_tests; i++) begin
            run_test(i);
        end

        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hdl/sift_pkg.sv
hdl/frame_ram.sv
hdl/line_buffer.sv
hdl/gaussian_blur.sv
hdl/keypoint_detect.sv
hdl/sift_core.sv
bench/clock_gen.sv
bench/sift_core_tb.sv

// File: hdl/frame_ram.sv
`default_nettype none

module frame_ram #(
    parameter int data_w = 8,
    parameter int depth = 256
) (
    input  wire                      clk,
    input  wire                      we,
    input  wire [$clog2(depth)-1:0]  addr,
    input  wire [data_w-1:0]         din,
    output logic [data_w-1:0]        dout
);

    logic [data_w-1:0] mem [0:depth-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
            dout <= din;  // write-first
        end else begin
            dout <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// File: hdl/gaussian_blur.sv
`default_nettype none

module gaussian_blur (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          start,
    output logic                         done,
    output logic [sift_pkg::addr_w-1:0]  img_addr,
    input  wire sift_pkg::pixel_t        img_dout,
    output logic                         blur_we,
    output logic [sift_pkg::addr_w-1:0]  blur_addr,
    output sift_pkg::pixel_t             blur_din,
    output logic                         lb_shift,
    output logic                         lb_zero_fill,
    output sift_pkg::pixel_t             lb_pix,
    input  wire sift_pkg::pixel_t        window [0:8]
);

    import sift_pkg::*;

    localparam int pad_last = img_dim + 1;  // last padded row or column
    localparam int sum_w = pix_w + 4;

    logic                running;
    logic [coord_w:0]    pr;
    logic [coord_w:0]    pc;
    logic [coord_w:0]    r_img;
    logic [coord_w:0]    c_img;
    logic [coord_w:0]    r_ctr;
    logic [coord_w:0]    c_ctr;
    logic                in_image;
    logic                s1_valid;
    logic                s1_last;
    logic                s1_pad;
    logic                s1_win;
    logic [addr_w-1:0]   s1_addr;
    logic                s2_valid;
    logic                s2_last;
    logic [addr_w-1:0]   s2_addr;
    logic [sum_w-1:0]    sum;

    assign r_img = pr - 1'b1;
    assign c_img = pc - 1'b1;
    assign r_ctr = pr - 2'd2;  // window centre lags two positions
    assign c_ctr = pc - 2'd2;
    assign in_image = (pr != 0) && (pr != pad_last) && (pc != 0) && (pc != pad_last);
    assign img_addr = in_image ? {r_img[coord_w-1:0], c_img[coord_w-1:0]} : '0;

    // padded raster scan, 18x18
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running <= 1'b0;
            pr <= '0;
            pc <= '0;
        end else if (start) begin
            running <= 1'b1;
            pr <= '0;
            pc <= '0;
        end else if (running) begin
            if (pc == pad_last) begin
                pc <= '0;
                if (pr == pad_last) begin
                    running <= 1'b0;
                end else begin
                    pr <= pr + 1'b1;
                end
            end else begin
                pc <= pc + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_last <= 1'b0;
            s2_valid <= 1'b0;
            s2_last <= 1'b0;
            done <= 1'b0;
        end else begin
            s1_valid <= running;  // read data back
            s1_last <= running && (pr == pad_last) && (pc == pad_last);
            s2_valid <= s1_valid && s1_win;  // window centred in image
            s2_last <= s1_last;
            done <= s2_last;
        end
    end

    always_ff @(posedge clk) begin
        s1_pad <= !in_image;
        s1_win <= (pr >= 2) && (pc >= 2);
        s1_addr <= {r_ctr[coord_w-1:0], c_ctr[coord_w-1:0]};
        s2_addr <= s1_addr;
    end

    assign lb_shift = s1_valid;
    assign lb_zero_fill = s1_pad;
    assign lb_pix = img_dout;

    // 1-2-1 by 1-2-1 kernel
    always_comb begin
        sum = sum_w'(window[0]) + sum_w'(window[2]) + sum_w'(window[6]) + sum_w'(window[8]);
        sum = sum + (sum_w'(window[1]) << 1) + (sum_w'(window[3]) << 1);
        sum = sum + (sum_w'(window[5]) << 1) + (sum_w'(window[7]) << 1);
        sum = sum + (sum_w'(window[4]) << 2);
    end

    assign blur_we = s2_valid;
    assign blur_addr = s2_addr;
    assign blur_din = sum[sum_w-1:4];  // divide by 16, truncated

endmodule

`default_nettype wire

// File: hdl/keypoint_detect.sv
`default_nettype none

module keypoint_detect #(
    parameter int dog_thresh = sift_pkg::dog_thresh_def
) (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             start,
    output logic                            done,
    output logic [sift_pkg::addr_w-1:0]     img_addr,
    input  wire sift_pkg::pixel_t           img_dout,
    output logic [sift_pkg::addr_w-1:0]     blur_addr,
    input  wire sift_pkg::pixel_t           blur_dout,
    output logic                            kp_we,
    output logic [sift_pkg::kp_addr_w-2:0]  kp_addr,
    output sift_pkg::kp_t                   kp_din,
    output logic [sift_pkg::kp_addr_w-1:0]  kp_count
);

    import sift_pkg::*;

    logic                  running;
    logic [addr_w-1:0]     scan_addr;
    logic                  s1_valid;
    logic                  s1_last;
    logic [addr_w-1:0]     s1_addr;
    logic                  s2_valid;
    logic                  s2_last;
    logic [addr_w-1:0]     s2_addr;
    pixel_t                s2_mag;
    logic [kp_addr_w-1:0]  wr_ptr;

    // both memories read at the same address
    assign img_addr = scan_addr;
    assign blur_addr = scan_addr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running <= 1'b0;
            scan_addr <= '0;
        end else if (start) begin
            running <= 1'b1;
            scan_addr <= '0;
        end else if (running) begin
            scan_addr <= scan_addr + 1'b1;
            if (scan_addr == '1) begin
                running <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_last <= 1'b0;
            s2_valid <= 1'b0;
            s2_last <= 1'b0;
            done <= 1'b0;
        end else begin
            s1_valid <= running;
            s1_last <= running && (scan_addr == '1);
            s2_valid <= s1_valid;
            s2_last <= s1_last;
            done <= s2_last;  // last pixel drained
        end
    end

    // |original - blur|
    always_ff @(posedge clk) begin
        s1_addr <= scan_addr;
        s2_addr <= s1_addr;
        if (img_dout > blur_dout) begin
            s2_mag <= img_dout - blur_dout;
        end else begin
            s2_mag <= blur_dout - img_dout;
        end
    end

    assign kp_we = s2_valid && (s2_mag > dog_thresh);
    assign kp_addr = wr_ptr[kp_addr_w-2:0];
    assign kp_din = {s2_addr, s2_mag};  // address is already {row, col}
    assign kp_count = wr_ptr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (start) begin
            wr_ptr <= '0;
        end else if (kp_we) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/line_buffer.sv
`default_nettype none

module line_buffer (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    shift,
    input  wire                    zero_fill,
    input  wire sift_pkg::pixel_t  pix_in,
    output sift_pkg::pixel_t       window [0:8]
);

    import sift_pkg::*;

    localparam int row_len = img_dim + 2;  // one padded raster row

    pixel_t row1 [0:row_len-1];
    pixel_t row2 [0:row_len-1];
    pixel_t pix_sel;
    pixel_t tap1;
    pixel_t tap2;

    assign pix_sel = zero_fill ? '0 : pix_in;  // border padding
    assign tap1 = row1[row_len-1];  // one row back
    assign tap2 = row2[row_len-1];  // two rows back

    // row delay lines
    always_ff @(posedge clk) begin
        if (shift) begin
            row1[0] <= pix_sel;
            row2[0] <= tap1;
            for (int i = 1; i < row_len; i++) begin
                row1[i] <= row1[i-1];
                row2[i] <= row2[i-1];
            end
        end
    end

    // 3x3 neighborhood, index 0 is top left, newest column on the right
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 9; i++) begin
                window[i] <= '0;
            end
        end else if (shift) begin
            window[0] <= window[1];
            window[1] <= window[2];
            window[2] <= tap2;
            window[3] <= window[4];
            window[4] <= window[5];
            window[5] <= tap1;
            window[6] <= window[7];
            window[7] <= window[8];
            window[8] <= pix_sel;
        end
    end

endmodule

`default_nettype wire

// File: hdl/sift_core.sv
`default_nettype none

module sift_core #(
    parameter int dog_thresh = sift_pkg::dog_thresh_def
) (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            in_valid,
    input  wire [15:0]     in_data,
    output logic           out_valid,
    output sift_pkg::kp_t  out_data,
    output logic           done
);

    import sift_pkg::*;

    localparam int kp_depth = 2 ** (kp_addr_w - 1);

    phase_t                state;
    phase_t                state_nx;
    logic [addr_w-1:0]     load_addr;
    logic                  load_we;
    logic [addr_w-1:0]     ori_addr;
    pixel_t                ori_dout;
    logic                  blur_we;
    logic [addr_w-1:0]     blur_addr;
    pixel_t                blur_dout;
    logic                  kp_we;
    logic [kp_addr_w-2:0]  kp_addr;
    kp_t                   kp_dout;

    logic                  gb_start;
    logic                  gb_done;
    logic [addr_w-1:0]     gb_img_addr;
    logic                  gb_blur_we;
    logic [addr_w-1:0]     gb_blur_addr;
    pixel_t                gb_blur_din;
    logic                  lb_shift;
    logic                  lb_zero_fill;
    pixel_t                lb_pix;
    pixel_t                lb_window [0:8];

    logic                  kd_start;
    logic                  kd_done;
    logic [addr_w-1:0]     kd_img_addr;
    logic [addr_w-1:0]     kd_blur_addr;
    logic                  kd_kp_we;
    logic [kp_addr_w-2:0]  kd_kp_addr;
    kp_t                   kd_kp_din;
    logic [kp_addr_w-1:0]  kd_kp_count;

    logic [kp_addr_w-1:0]  kp_count_q;
    logic [kp_addr_w-1:0]  rd_ptr;
    logic                  rd_issue;
    logic                  rpt_end;

    frame_ram #(.data_w(pix_w), .depth(img_dim * img_dim)) ori_img (
        .clk  (clk),
        .we   (load_we),
        .addr (ori_addr),
        .din  (in_data[pix_w-1:0]),
        .dout (ori_dout)
    );

    frame_ram #(.data_w(pix_w), .depth(img_dim * img_dim)) blur_img (
        .clk  (clk),
        .we   (blur_we),
        .addr (blur_addr),
        .din  (gb_blur_din),
        .dout (blur_dout)
    );

    frame_ram #(.data_w(kp_w), .depth(kp_depth)) kp_mem (
        .clk  (clk),
        .we   (kp_we),
        .addr (kp_addr),
        .din  (kd_kp_din),
        .dout (kp_dout)
    );

    line_buffer u_line_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .shift     (lb_shift),
        .zero_fill (lb_zero_fill),
        .pix_in    (lb_pix),
        .window    (lb_window)
    );

    gaussian_blur u_gaussian_blur (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (gb_start),
        .done         (gb_done),
        .img_addr     (gb_img_addr),
        .img_dout     (ori_dout),
        .blur_we      (gb_blur_we),
        .blur_addr    (gb_blur_addr),
        .blur_din     (gb_blur_din),
        .lb_shift     (lb_shift),
        .lb_zero_fill (lb_zero_fill),
        .lb_pix       (lb_pix),
        .window       (lb_window)
    );

    keypoint_detect #(.dog_thresh(dog_thresh)) u_keypoint_detect (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (kd_start),
        .done      (kd_done),
        .img_addr  (kd_img_addr),
        .img_dout  (ori_dout),
        .blur_addr (kd_blur_addr),
        .blur_dout (blur_dout),
        .kp_we     (kd_kp_we),
        .kp_addr   (kd_kp_addr),
        .kp_din    (kd_kp_din),
        .kp_count  (kd_kp_count)
    );

    // the idle beat is pixel 0
    assign load_we = in_valid && ((state == ph_idle) || (state == ph_load));
    assign rd_issue = (state == ph_report) && (rd_ptr != kp_count_q);
    assign rpt_end = (state == ph_report) && (rd_ptr == kp_count_q);
    assign out_data = kp_dout;

    always_comb begin
        state_nx = state;
        case (state)
            ph_idle:   if (in_valid) state_nx = ph_load;
            ph_load:   if (in_valid && (load_addr == '1)) state_nx = ph_blur;
            ph_blur:   if (gb_done) state_nx = ph_detect;
            ph_detect: if (kd_done) state_nx = ph_report;
            ph_report: if (rpt_end) state_nx = ph_idle;
            default:   state_nx = ph_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ph_idle;
            load_addr <= '0;
            gb_start <= 1'b0;
            kd_start <= 1'b0;
            kp_count_q <= '0;
            rd_ptr <= '0;
            out_valid <= 1'b0;
            done <= 1'b0;
        end else begin
            state <= state_nx;
            if (load_we) begin
                load_addr <= load_addr + 1'b1;  // wraps to 0 after 256 beats
            end
            gb_start <= (state != ph_blur) && (state_nx == ph_blur);
            kd_start <= (state != ph_detect) && (state_nx == ph_detect);
            if (kd_done) begin
                kp_count_q <= kd_kp_count;
            end
            if (state != ph_report) begin
                rd_ptr <= '0;
            end else if (rd_issue) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            out_valid <= rd_issue;  // memory read latency
            done <= rpt_end;
        end
    end

    // memory ports follow the phase owner
    always_comb begin
        ori_addr = '0;
        blur_addr = '0;
        blur_we = 1'b0;
        kp_addr = '0;
        kp_we = 1'b0;
        case (state)
            ph_idle, ph_load: begin
                ori_addr = load_addr;
            end
            ph_blur: begin
                ori_addr = gb_img_addr;
                blur_addr = gb_blur_addr;
                blur_we = gb_blur_we;
            end
            ph_detect: begin
                ori_addr = kd_img_addr;
                blur_addr = kd_blur_addr;
                kp_addr = kd_kp_addr;
                kp_we = kd_kp_we;
            end
            ph_report: begin
                kp_addr = rd_ptr[kp_addr_w-2:0];
            end
            default: begin
                ori_addr = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/sift_pkg.sv
`default_nettype none

package sift_pkg;

    // image geometry
    localparam int img_dim = 16;
    localparam int pix_w = 8;
    localparam int addr_w = 8;        // row * img_dim + col
    localparam int coord_w = 4;

    // keypoint word is {row, col, dog magnitude}
    localparam int kp_w = 16;
    localparam int kp_addr_w = 9;     // count can reach 256

    localparam int dog_thresh_def = 20;

    typedef enum logic [2:0] {
        ph_idle,
        ph_load,
        ph_blur,
        ph_detect,
        ph_report
    } phase_t;

    typedef logic [pix_w-1:0] pixel_t;
    typedef logic [kp_w-1:0] kp_t;

endpackage

`default_nettype wire
